/* logic/pipe_pkg.sv */
package pipe_pkg;

    // Codes 7 to 15 are not decoded and behave as nop
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_ldi  = 4'h1,
        op_add  = 4'h2,
        op_sub  = 4'h3,
        op_ld   = 4'h4,
        op_st   = 4'h5,
        op_halt = 4'h6
    } opcode_t;

    typedef logic [2:0] tag_t;

    typedef struct packed {
        opcode_t    op;
        logic [1:0] rd;
        logic [1:0] rs;
        logic [7:0] imm;
    } instr_t;

    // Destination of an instruction still in flight, used by the hazard check
    typedef struct packed {
        logic       valid;
        logic [1:0] rd;
    } dst_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic [7:0] pc;
        opcode_t    op;
        logic [1:0] rd;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] imm;
    } de_payload_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic [7:0] pc;
        opcode_t    op;
        logic [1:0] rd;
        logic [7:0] result;
        logic [7:0] addr;
    } em_payload_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic [7:0] pc;
        opcode_t    op;
        logic [1:0] rd;
        logic [7:0] value;
    } wb_payload_t;

    typedef struct packed {
        logic [7:0] pc;
        opcode_t    op;
        logic [7:0] stall_cycles;
        logic [7:0] latency;
    } retire_rec_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [7:0]  addr;
        logic [15:0] wdata;
    } mem_req_t;

    function automatic logic writes_reg(opcode_t op);
        return (op == op_ldi) || (op == op_add) || (op == op_sub) || (op == op_ld);
    endfunction

endpackage

/* logic/shared_mem.sv */
`timescale 1ns/1ps

module shared_mem import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    host_req,
    input  mem_req_t    mem_req,
    input  mem_req_t    fetch_req,
    output logic        host_gnt,
    output logic        mem_gnt,
    output logic        fetch_gnt,
    output logic [15:0] rdata
);

    logic [15:0] mem [256];
    mem_req_t    sel;

    // Fixed priority: host, then the memory stage, then fetch
    always_comb begin
        host_gnt  = host_req.req;
        mem_gnt   = mem_req.req && !host_req.req;
        fetch_gnt = fetch_req.req && !host_req.req && !mem_req.req;
    end

    always_comb begin
        if (host_gnt) begin
            sel = host_req;
        end else if (mem_gnt) begin
            sel = mem_req;
        end else begin
            sel = fetch_req;
        end
    end

    // Writes land at the grant edge, reads show up the cycle after
    always_ff @(posedge clk) begin
        if (sel.req && sel.we) begin
            mem[sel.addr] <= sel.wdata;
        end
        if (sel.req && !sel.we) begin
            rdata <= mem[sel.addr];
        end
    end

    // The host owns the memory only while the core is stopped
    a_host_alone: assert property (
        @(posedge clk) disable iff (rst)
        host_req.req |-> !(mem_req.req || fetch_req.req)
    );

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import pipe_pkg::*; #(
    parameter int MAX_TAGS = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        stall,
    input  logic        halt_seen,
    input  logic        gnt,
    input  logic [15:0] rdata,
    output mem_req_t    req,
    output logic        fetch_pulse,
    output tag_t        fetch_tag,
    output instr_t      instr,
    output logic [7:0]  instr_pc,
    output logic        instr_valid
);

    logic [7:0] pc;
    tag_t       next_tag;
    logic       done;
    logic       pend;
    logic       granted;
    instr_t     held;
    logic       held_valid;

    always_comb begin
        req       = '0;
        req.req   = run && !stall && !halt_seen && !done;
        req.addr  = pc;
        granted   = req.req && gnt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            next_tag   <= '0;
            done       <= 1'b0;
            pend       <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            pend <= granted;
            // Nothing past a halt is ever fetched
            if (halt_seen) begin
                done <= 1'b1;
            end
            if (granted) begin
                pc       <= pc + 8'd1;
                next_tag <= (next_tag == tag_t'(MAX_TAGS - 1)) ? '0 : next_tag + tag_t'(1);
            end
            if (pend && stall) begin
                held_valid <= 1'b1;
            end else if (!stall) begin
                held_valid <= 1'b0;
            end
        end
    end

    // The read bus moves on, so a stalled word is parked here
    always_ff @(posedge clk) begin
        if (granted) begin
            instr_pc  <= pc;
            fetch_tag <= next_tag;
        end
        if (pend && stall) begin
            held <= instr_t'(rdata);
        end
    end

    assign instr       = held_valid ? held : instr_t'(rdata);
    assign instr_valid = pend || held_valid;
    assign fetch_pulse = pend;  // one per granted word, as it returns

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  instr_t      instr,
    input  logic [7:0]  instr_pc,
    input  logic        instr_valid,
    input  tag_t        fetch_tag,
    input  dst_t        exec_dst,
    input  dst_t        mem_dst,
    input  wb_payload_t wb,
    input  logic        hold,
    output de_payload_t de,
    output logic        stall,
    output logic        halt_seen
);

    logic [7:0] regs [4];
    opcode_t    dec_op;
    dst_t       wb_dst;
    logic       reads_rd;
    logic       reads_rs;
    logic       hazard;

    function automatic logic clash(dst_t d, logic [1:0] r);
        return d.valid && (d.rd == r);
    endfunction

    always_comb begin
        case (instr.op)
            op_ldi, op_add, op_sub, op_ld, op_st, op_halt: dec_op = instr.op;
            default: dec_op = op_nop;
        endcase
    end

    always_comb begin
        reads_rd = (dec_op == op_add) || (dec_op == op_sub) || (dec_op == op_st);
        reads_rs = (dec_op == op_add) || (dec_op == op_sub);
        wb_dst   = '{valid: wb.valid && writes_reg(wb.op), rd: wb.rd};
        // Any pending writer of a source register blocks issue
        hazard   = (reads_rd && (clash(exec_dst, instr.rd) || clash(mem_dst, instr.rd)
                                 || clash(wb_dst, instr.rd)))
                || (reads_rs && (clash(exec_dst, instr.rs) || clash(mem_dst, instr.rs)
                                 || clash(wb_dst, instr.rs)));
        stall     = instr_valid && (hazard || hold);
        halt_seen = instr_valid && (dec_op == op_halt);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && writes_reg(wb.op)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            de.valid <= 1'b0;
        end else if (!hold) begin
            // Bubble out while the hazard lasts
            de.valid <= instr_valid && !hazard;
            de.tag   <= fetch_tag;
            de.pc    <= instr_pc;
            de.op    <= dec_op;
            de.rd    <= instr.rd;
            de.a     <= regs[instr.rd];
            de.b     <= regs[instr.rs];
            de.imm   <= instr.imm;
        end
    end

    // A stalled instruction must still sit unchanged in decode on the next cycle
    a_stall_keeps_instr: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> instr_valid && $stable(instr)
    );

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  de_payload_t de,
    input  logic        hold,
    output em_payload_t em,
    output dst_t        exec_dst
);

    logic [7:0] result;

    always_comb begin
        case (de.op)
            op_ldi:  result = de.imm;
            op_add:  result = de.a + de.b;
            op_sub:  result = de.a - de.b;
            // Store data rides in the result field
            op_st:   result = de.a;
            default: result = 8'h00;
        endcase
    end

    assign exec_dst = '{valid: de.valid && writes_reg(de.op), rd: de.rd};

    always_ff @(posedge clk) begin
        if (rst) begin
            em.valid <= 1'b0;
        end else if (!hold) begin
            em.valid  <= de.valid;
            em.tag    <= de.tag;
            em.pc     <= de.pc;
            em.op     <= de.op;
            em.rd     <= de.rd;
            em.result <= result;
            em.addr   <= de.imm;
        end
    end

endmodule

/* logic/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  em_payload_t em,
    input  logic        gnt,
    input  logic [15:0] rdata,
    output mem_req_t    req,
    output logic        hold,
    output wb_payload_t wb,
    output dst_t        mem_dst,
    output logic        halted
);

    logic        is_mem;
    wb_payload_t wb_q;

    always_comb begin
        is_mem    = em.valid && ((em.op == op_ld) || (em.op == op_st));
        req       = '0;
        req.req   = is_mem;
        req.we    = (em.op == op_st);
        req.addr  = em.addr;
        req.wdata = {8'h00, em.result};
        hold      = is_mem && !gnt;
    end

    assign mem_dst = '{valid: em.valid && writes_reg(em.op), rd: em.rd};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= em.valid && !hold;
            wb_q.tag   <= em.tag;
            wb_q.pc    <= em.pc;
            wb_q.op    <= em.op;
            wb_q.rd    <= em.rd;
            wb_q.value <= em.result;
        end
    end

    // Load data arrives on the bus in the writeback cycle
    always_comb begin
        wb = wb_q;
        if (wb_q.op == op_ld) begin
            wb.value = rdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (wb_q.valid && (wb_q.op == op_halt)) begin
            halted <= 1'b1;
        end
    end

endmodule

/* logic/pipeline_tracker.sv */
`timescale 1ns/1ps

module pipeline_tracker import pipe_pkg::*; #(
    parameter int MAX_TAGS = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_pulse,
    input  tag_t        fetch_tag,
    input  logic        stall,
    input  tag_t        decode_tag,
    input  wb_payload_t wb,
    output logic        retire_valid,
    output retire_rec_t retire_rec
);

    logic [7:0]          cycle;
    logic [7:0]          fetch_cyc [MAX_TAGS];
    logic [7:0]          stall_cnt [MAX_TAGS];
    logic [MAX_TAGS-1:0] live;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '0;
        end else begin
            for (int i = 0; i < MAX_TAGS; i++) begin
                if (wb.valid && (wb.tag == tag_t'(i))) begin
                    live[i] <= 1'b0;
                end
                if (fetch_pulse && (fetch_tag == tag_t'(i))) begin
                    live[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_TAGS; i++) begin
            if (fetch_pulse && (fetch_tag == tag_t'(i))) begin
                // Pulse trails the request by one cycle
                fetch_cyc[i] <= cycle - 8'd1;
                stall_cnt[i] <= (stall && (decode_tag == tag_t'(i))) ? 8'd1 : 8'd0;
            end else if (stall && (decode_tag == tag_t'(i))) begin
                stall_cnt[i] <= stall_cnt[i] + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb.valid;
            if (wb.valid) begin
                retire_rec.pc           <= wb.pc;
                retire_rec.op           <= wb.op;
                retire_rec.stall_cycles <= stall_cnt[wb.tag];
                retire_rec.latency      <= cycle - fetch_cyc[wb.tag];
            end
        end
    end

    // Tag reuse before retirement would merge two histories
    a_tag_free: assert property (
        @(posedge clk) disable iff (rst)
        fetch_pulse |-> !live[fetch_tag]
    );

endmodule

/* logic/pipe_core_top.sv */
`timescale 1ns/1ps

module pipe_core_top import pipe_pkg::*; #(
    parameter int MAX_TAGS = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  mem_req_t    host_req,
    output logic        host_gnt,
    output logic [15:0] host_rdata,
    output logic        retire_valid,
    output retire_rec_t retire_rec,
    output logic        halted
);

    mem_req_t    fetch_req;
    mem_req_t    mem_req;
    logic        fetch_gnt;
    logic        mem_gnt;
    logic        stall;
    logic        halt_seen;
    logic        mem_hold;
    logic        fetch_pulse;
    tag_t        fetch_tag;
    instr_t      instr;
    logic [7:0]  instr_pc;
    logic        instr_valid;
    de_payload_t de;
    em_payload_t em;
    wb_payload_t wb;
    dst_t        exec_dst;
    dst_t        mem_dst;

    shared_mem u_mem (
        .clk(clk), .rst(rst), .host_req(host_req), .mem_req(mem_req),
        .fetch_req(fetch_req), .host_gnt(host_gnt), .mem_gnt(mem_gnt),
        .fetch_gnt(fetch_gnt), .rdata(host_rdata)
    );

    fetch_stage #(.MAX_TAGS(MAX_TAGS)) u_fetch (
        .clk(clk), .rst(rst), .run(run), .stall(stall), .halt_seen(halt_seen),
        .gnt(fetch_gnt), .rdata(host_rdata), .req(fetch_req),
        .fetch_pulse(fetch_pulse), .fetch_tag(fetch_tag), .instr(instr),
        .instr_pc(instr_pc), .instr_valid(instr_valid)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .instr(instr), .instr_pc(instr_pc),
        .instr_valid(instr_valid), .fetch_tag(fetch_tag), .exec_dst(exec_dst),
        .mem_dst(mem_dst), .wb(wb), .hold(mem_hold), .de(de), .stall(stall),
        .halt_seen(halt_seen)
    );

    exec_stage u_exec (
        .clk(clk), .rst(rst), .de(de), .hold(mem_hold), .em(em), .exec_dst(exec_dst)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .rst(rst), .em(em), .gnt(mem_gnt), .rdata(host_rdata),
        .req(mem_req), .hold(mem_hold), .wb(wb), .mem_dst(mem_dst), .halted(halted)
    );

    // The instruction in decode carries the tag fetch gave it
    pipeline_tracker #(.MAX_TAGS(MAX_TAGS)) u_tracker (
        .clk(clk), .rst(rst), .fetch_pulse(fetch_pulse), .fetch_tag(fetch_tag),
        .stall(stall), .decode_tag(fetch_tag), .wb(wb),
        .retire_valid(retire_valid), .retire_rec(retire_rec)
    );

endmodule

/* sim/tb_pipe_core.sv */
`timescale 1ns/1ps

module tb_pipe_core import pipe_pkg::*; ();

    localparam int NUM_CASES = 4;
    localparam int RUN_LIMIT = 200;
    localparam int GNT_LIMIT = 20;

    // One table entry: program, expected retire sequence and one data check
    typedef struct packed {
        logic [3:0]       n_instr;
        logic [7:0][15:0] prog;
        logic [7:0][7:0]  exp_pc;
        logic [7:0][3:0]  exp_op;
        logic [7:0]       stall_nz;
        logic [7:0]       data_addr;
        logic [7:0]       data_val;
    } case_t;

    logic        clk;
    logic        rst;
    logic        run;
    mem_req_t    host_req;
    logic        host_gnt;
    logic [15:0] host_rdata;
    logic        retire_valid;
    retire_rec_t retire_rec;
    logic        halted;

    case_t       cases [NUM_CASES];
    string       names [NUM_CASES];
    retire_rec_t recs [$];
    int          errors;
    int          case_errors;
    int          cases_run;
    int          cases_passed;
    bit          timed_out;
    logic [15:0] rd_word;

    pipe_core_top #(.MAX_TAGS(8)) dut (
        .clk(clk), .rst(rst), .run(run), .host_req(host_req), .host_gnt(host_gnt),
        .host_rdata(host_rdata), .retire_valid(retire_valid), .retire_rec(retire_rec),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Inputs change 2 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) next_cycle();
        rst = 1'b0;
    endtask

    task automatic report_error(string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
        case_errors++;
    endtask

    // Single host transfer; read data is valid just after the grant edge
    task automatic host_access(logic we, logic [7:0] addr, logic [15:0] wdata);
        int waited;
        waited = 0;
        host_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
        @(posedge clk);
        while (!host_gnt && !timed_out) begin
            waited++;
            if (waited > GNT_LIMIT) begin
                $display("Timed out waiting for a host port grant at address %0h", addr);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        #2;
        host_req = '0;
    endtask

    task automatic add_instr(int idx, opcode_t op, logic [1:0] rd, logic [1:0] rs,
                             logic [7:0] imm, logic stalls);
        int n;
        n = int'(cases[idx].n_instr);
        cases[idx].prog[n]     = {op, rd, rs, imm};
        // No branches, so pc follows program order
        cases[idx].exp_pc[n]   = 8'(n);
        cases[idx].exp_op[n]   = op;
        cases[idx].stall_nz[n] = stalls;
        cases[idx].n_instr     = cases[idx].n_instr + 4'd1;
    endtask

    task automatic build_cases();
        foreach (cases[i]) begin
            cases[i] = '0;
        end
        names[0] = "independent ldi";
        add_instr(0, op_ldi, 2'd0, 2'd0, 8'h11, 1'b0);
        add_instr(0, op_ldi, 2'd1, 2'd0, 8'h22, 1'b0);
        add_instr(0, op_ldi, 2'd2, 2'd0, 8'h33, 1'b0);
        add_instr(0, op_ldi, 2'd3, 2'd0, 8'h44, 1'b0);
        // r0 has left writeback by the time this store decodes
        add_instr(0, op_st, 2'd0, 2'd0, 8'h80, 1'b0);
        add_instr(0, op_halt, 2'd0, 2'd0, 8'h00, 1'b0);
        cases[0].data_addr = 8'h80;
        cases[0].data_val  = 8'h11;
        names[1] = "dependent add";
        add_instr(1, op_ldi, 2'd0, 2'd0, 8'hC8, 1'b0);
        add_instr(1, op_ldi, 2'd1, 2'd0, 8'h5A, 1'b0);
        add_instr(1, op_add, 2'd0, 2'd1, 8'h00, 1'b1);
        add_instr(1, op_st, 2'd0, 2'd0, 8'h81, 1'b1);
        add_instr(1, op_halt, 2'd0, 2'd0, 8'h00, 1'b0);
        cases[1].data_addr = 8'h81;
        cases[1].data_val  = 8'(8'hC8 + 8'h5A);
        names[2] = "dependent sub";
        add_instr(2, op_ldi, 2'd3, 2'd0, 8'h30, 1'b0);
        add_instr(2, op_ldi, 2'd2, 2'd0, 8'h45, 1'b0);
        add_instr(2, op_sub, 2'd3, 2'd2, 8'h00, 1'b1);
        add_instr(2, op_st, 2'd3, 2'd0, 8'h82, 1'b1);
        add_instr(2, op_halt, 2'd0, 2'd0, 8'h00, 1'b0);
        cases[2].data_addr = 8'h82;
        cases[2].data_val  = 8'(8'h30 - 8'h45);
        names[3] = "store then load";
        add_instr(3, op_ldi, 2'd1, 2'd0, 8'h7E, 1'b0);
        add_instr(3, op_st, 2'd1, 2'd0, 8'h83, 1'b1);
        add_instr(3, op_ld, 2'd2, 2'd0, 8'h83, 1'b0);
        add_instr(3, op_st, 2'd2, 2'd0, 8'h84, 1'b1);
        add_instr(3, op_halt, 2'd0, 2'd0, 8'h00, 1'b0);
        cases[3].data_addr = 8'h84;
        cases[3].data_val  = 8'h7E;
    endtask

    task automatic load_case(int idx);
        // Data words get a high byte no store can produce
        for (int k = 0; k < 8; k++) begin
            host_access(1'b1, 8'h80 + 8'(k), 16'($urandom()) | 16'h8000);
        end
        for (int k = 0; k < 8; k++) begin
            host_access(1'b1, 8'(k), cases[idx].prog[k]);
        end
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        recs.delete();
        run = 1'b1;
        while (!timed_out) begin
            next_cycle();
            if (retire_valid) begin
                recs.push_back(retire_rec);
            end
            if (halted) begin
                break;
            end
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("Timed out waiting for the core to halt");
                timed_out = 1'b1;
            end
        end
        // Watch a few more cycles for stray records
        repeat (6) begin
            next_cycle();
            if (retire_valid) begin
                recs.push_back(retire_rec);
            end
        end
        run = 1'b0;
    endtask

    task automatic check_case(int idx);
        case_t c;
        int    n;
        c = cases[idx];
        n = int'(c.n_instr);
        if (recs.size() != n) begin
            report_error($sformatf("case %0d retired %0d records, expected %0d",
                                   idx, recs.size(), n));
        end
        for (int i = 0; i < recs.size() && i < n; i++) begin
            if (recs[i].pc !== c.exp_pc[i]) begin
                report_error($sformatf("record %0d pc %0h, expected %0h",
                                       i, recs[i].pc, c.exp_pc[i]));
            end
            if (recs[i].op !== c.exp_op[i]) begin
                report_error($sformatf("record %0d opcode %0h, expected %0h",
                                       i, recs[i].op, c.exp_op[i]));
            end
            if ((recs[i].stall_cycles != 8'd0) !== c.stall_nz[i]) begin
                report_error($sformatf("record %0d stall_cycles %0d, expected %s",
                                       i, recs[i].stall_cycles,
                                       c.stall_nz[i] ? "nonzero" : "zero"));
            end
            if (int'(recs[i].latency) < 4 + int'(recs[i].stall_cycles)) begin
                report_error($sformatf("record %0d latency %0d below 4 + %0d",
                                       i, recs[i].latency, recs[i].stall_cycles));
            end
        end
        if (recs.size() > 0 && recs[recs.size() - 1].op !== op_halt) begin
            report_error("last record is not the halt");
        end
        host_access(1'b0, c.data_addr, 16'h0000);
        rd_word = host_rdata;
        if (!timed_out && rd_word !== {8'h00, c.data_val}) begin
            report_error($sformatf("mem[%0h] = %0h, expected %0h",
                                   c.data_addr, rd_word, {8'h00, c.data_val}));
        end
    endtask

    initial begin
        int seed_ret;
        rst          = 1'b1;
        run          = 1'b0;
        host_req     = '0;
        errors       = 0;
        cases_run    = 0;
        cases_passed = 0;
        timed_out    = 1'b0;
        seed_ret     = $urandom(68183);
        build_cases();
        for (int idx = 0; idx < NUM_CASES && !timed_out; idx++) begin
            case_errors = 0;
            apply_reset();
            load_case(idx);
            run_program();
            if (!timed_out) begin
                check_case(idx);
            end
            cases_run++;
            if (case_errors == 0 && !timed_out) begin
                cases_passed++;
                $display("Case %0d (%s) passed", idx, names[idx]);
            end else begin
                $display("Case %0d (%s) failed", idx, names[idx]);
            end
        end
        $display("Cases run %0d, passed %0d, failed %0d, errors %0d",
                 cases_run, cases_passed, cases_run - cases_passed, errors);
        if (errors == 0 && !timed_out && cases_passed == NUM_CASES) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/pipe_pkg.sv
logic/shared_mem.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_wb_stage.sv
logic/pipeline_tracker.sv
logic/pipe_core_top.sv
sim/tb_pipe_core.sv
